// File: design/adc_rx_pkg.sv
`default_nettype none

package adc_rx_pkg;

  ////////////////////
  // widths
  ////////////////////

  // one ddr lane, one edge
  localparam int LANE_W = 7;
  // left-justified sample, two low bits zero
  localparam int SAMPLE_W = 16;
  // status level field, bits 15:8
  localparam int LVL_W = 8;
  // drop count
  localparam int DROP_W = 16;

  ////////////////////
  // converter pins
  ////////////////////

  // rise half = even bits, fall half = odd bits
  typedef struct packed {
    logic [LANE_W-1:0] rise;
    logic [LANE_W-1:0] fall;
  } lane_pair_t;

  typedef struct packed {
    lane_pair_t a;
    lane_pair_t b;
    // out of range pin
    logic       ovr;
  } adc_pins_t;

  // channel a on top, b below
  typedef struct packed {
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
  } sample_word_t;

  ////////////////////
  // apb
  ////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register map, byte addresses
  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_STATUS = 4'h4,
    REG_DATA   = 4'h8,
    REG_DROPS  = 4'hC
  } reg_addr_e;

  // slave states, one wait state per transfer
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } apb_state_e;

endpackage

`default_nettype wire

// File: design/sample_assembler.sv
`default_nettype none

module sample_assembler (
  input  logic                     adc0_clk,
  input  logic                     cfg_rst,
  input  adc_rx_pkg::adc_pins_t    adc_in,
  input  logic                     enable,
  output adc_rx_pkg::sample_word_t word,
  output logic                     word_valid,
  output logic                     ovr_seen
);

  import adc_rx_pkg::*;

  // stage 1 capture
  lane_pair_t          lane_a_q;
  lane_pair_t          lane_b_q;
  // stage 2 interleave
  logic [SAMPLE_W-1:0] samp_a_q;
  logic [SAMPLE_W-1:0] samp_b_q;

  // odd bits from the fall half, even bits from the rise half
  // bit 2k+3 <- fall[k], bit 2k+2 <- rise[k]
  function automatic logic [SAMPLE_W-1:0] interleave(input lane_pair_t p);
    logic [SAMPLE_W-1:0] s;
    s = '0;
    for (int k = 0; k < LANE_W; k++) begin
      s[2*k+3] = p.fall[k];
      s[2*k+2] = p.rise[k];
    end
    // bits 1:0 stay zero
    return s;
  endfunction

  ////////////////////
  // datapath
  ////////////////////

  always_ff @(posedge adc0_clk) begin
    // capture both lane pairs on the same edge
    lane_a_q <= adc_in.a;
    lane_b_q <= adc_in.b;
    // build the samples
    samp_a_q <= interleave(lane_a_q);
    samp_b_q <= interleave(lane_b_q);
    // pack, a over b
    word.a   <= samp_a_q;
    word.b   <= samp_b_q;
  end

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge adc0_clk or posedge cfg_rst) begin
    if (cfg_rst) begin
      word_valid <= 1'b0;
      ovr_seen   <= 1'b0;
    end else begin
      // strobe sits with the pack stage
      word_valid <= enable;
      // ovr pin registered once, flag sets one edge later
      ovr_seen   <= adc_in.ovr;
    end
  end

endmodule

`default_nettype wire

// File: design/sample_fifo.sv
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                          adc0_clk,
  input  logic                          cfg_rst,
  input  adc_rx_pkg::sample_word_t      wr_word,
  input  logic                          wr_valid,
  input  logic                          pop,
  output adc_rx_pkg::sample_word_t      rd_word,
  output logic                          empty,
  output logic                          full,
  output logic [adc_rx_pkg::LVL_W-1:0]  level,
  output logic                          drop
);

  import adc_rx_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  sample_word_t     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // no back-pressure, a word arriving while full is lost
  assign do_wr = wr_valid & ~full;
  assign drop  = wr_valid & full;
  // pop on empty is ignored
  assign do_rd = pop & ~empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign level = LVL_W'(count);

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge adc0_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_word;
    end
    // registered read, valid the cycle after pop
    if (do_rd) begin
      rd_word <= mem[rd_ptr];
    end
  end

  ////////////////////
  // pointers, count
  ////////////////////

  always_ff @(posedge adc0_clk or posedge cfg_rst) begin
    if (cfg_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/drop_counter.sv
`default_nettype none

module drop_counter (
  input  logic                          adc0_clk,
  input  logic                          cfg_rst,
  input  logic                          drop,
  input  logic                          clear,
  output logic [adc_rx_pkg::DROP_W-1:0] drops
);

  import adc_rx_pkg::*;

  logic at_max;

  // stick at all ones
  assign at_max = &drops;

  ////////////////////
  // count
  ////////////////////

  always_ff @(posedge adc0_clk or posedge cfg_rst) begin
    if (cfg_rst) begin
      drops <= '0;
    end else if (clear) begin
      // host clear wins over a drop in the same cycle
      drops <= '0;
    end else if (drop && !at_max) begin
      drops <= drops + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/apb_reg_fsm.sv
`default_nettype none

module apb_reg_fsm (
  input  logic                          adc0_clk,
  input  logic                          cfg_rst,
  input  adc_rx_pkg::apb_req_t          apb_req,
  output adc_rx_pkg::apb_rsp_t          apb_rsp,
  input  logic                          ovr_seen,
  input  adc_rx_pkg::sample_word_t      rd_word,
  input  logic                          empty,
  input  logic                          full,
  input  logic [adc_rx_pkg::LVL_W-1:0]  level,
  input  logic [adc_rx_pkg::DROP_W-1:0] drops,
  output logic                          enable,
  output logic                          pop,
  output logic                          clear
);

  import adc_rx_pkg::*;

  apb_state_e  state;
  reg_addr_e   addr;
  logic        in_access;
  logic        wr_acc;
  logic        rd_acc;
  logic [31:0] rd_val;
  logic        acc_err;
  // response registers
  logic [31:0] rdata_q;
  logic        err_q;
  logic        data_q;
  logic        ovr_flag;

  assign addr      = reg_addr_e'(apb_req.paddr);
  assign in_access = (state == ACCESS);
  assign wr_acc    = in_access & apb_req.pwrite;
  assign rd_acc    = in_access & ~apb_req.pwrite;

  ////////////////////
  // bus fsm
  ////////////////////

  always_ff @(posedge adc0_clk or posedge cfg_rst) begin
    if (cfg_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        // setup phase seen, access phase follows
        IDLE:    if (apb_req.psel && !apb_req.penable) state <= ACCESS;
        // one wait state
        ACCESS:  state <= RESPOND;
        // pready for exactly one cycle
        RESPOND: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // decode
  ////////////////////

  always_comb begin
    rd_val  = '0;
    acc_err = 1'b0;
    case (addr)
      REG_CTRL:   rd_val = {31'd0, enable};
      REG_STATUS: rd_val = {16'd0, level, 5'd0, ovr_flag, full, empty};
      // read of an empty buffer errors and returns 0
      REG_DATA:   acc_err = ~apb_req.pwrite & empty;
      REG_DROPS:  rd_val = {{(32-DROP_W){1'b0}}, drops};
      default:    acc_err = 1'b1;
    endcase
  end

  // pop in ACCESS, word lands in rd_word for RESPOND
  assign pop   = rd_acc & (addr == REG_DATA) & ~empty;
  // any write to DROPS
  assign clear = wr_acc & (addr == REG_DROPS);

  ////////////////////
  // control, status
  ////////////////////

  always_ff @(posedge adc0_clk or posedge cfg_rst) begin
    if (cfg_rst) begin
      enable   <= 1'b0;
      ovr_flag <= 1'b0;
      err_q    <= 1'b0;
      data_q   <= 1'b0;
    end else begin
      if (wr_acc && addr == REG_CTRL) begin
        enable <= apb_req.pwdata[0];
      end
      // sticky, a new ovr beats the write-one clear
      if (ovr_seen) begin
        ovr_flag <= 1'b1;
      end else if (wr_acc && addr == REG_STATUS && apb_req.pwdata[2]) begin
        ovr_flag <= 1'b0;
      end
      // held only through RESPOND
      err_q  <= in_access & acc_err;
      data_q <= pop;
    end
  end

  // read data for the register reads
  always_ff @(posedge adc0_clk) begin
    if (in_access) begin
      rdata_q <= rd_acc ? rd_val : '0;
    end
  end

  always_comb begin
    apb_rsp.prdata  = data_q ? rd_word : rdata_q;
    apb_rsp.pready  = (state == RESPOND);
    apb_rsp.pslverr = err_q;
  end

endmodule

`default_nettype wire

// File: design/adc_rx_top.sv
`default_nettype none

module adc_rx_top #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  adc0_clk,
  input  logic                  cfg_rst,
  input  adc_rx_pkg::adc_pins_t adc_in,
  input  adc_rx_pkg::apb_req_t  apb_req,
  output adc_rx_pkg::apb_rsp_t  apb_rsp
);

  import adc_rx_pkg::*;

  // assembler to buffer
  sample_word_t      word;
  logic              word_valid;
  logic              ovr_seen;
  // buffer to registers
  sample_word_t      rd_word;
  logic              empty;
  logic              full;
  logic [LVL_W-1:0]  level;
  logic              drop;
  // registers back out
  logic              enable;
  logic              pop;
  logic              clear;
  logic [DROP_W-1:0] drops;

  ////////////////////
  // capture path
  ////////////////////

  sample_assembler i_asm (
    .adc0_clk   (adc0_clk),
    .cfg_rst    (cfg_rst),
    .adc_in     (adc_in),
    .enable     (enable),
    .word       (word),
    .word_valid (word_valid),
    .ovr_seen   (ovr_seen)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .adc0_clk (adc0_clk),
    .cfg_rst  (cfg_rst),
    .wr_word  (word),
    .wr_valid (word_valid),
    .pop      (pop),
    .rd_word  (rd_word),
    .empty    (empty),
    .full     (full),
    .level    (level),
    .drop     (drop)
  );

  drop_counter i_drops (
    .adc0_clk (adc0_clk),
    .cfg_rst  (cfg_rst),
    .drop     (drop),
    .clear    (clear),
    .drops    (drops)
  );

  ////////////////////
  // host side
  ////////////////////

  apb_reg_fsm i_regs (
    .adc0_clk (adc0_clk),
    .cfg_rst  (cfg_rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .ovr_seen (ovr_seen),
    .rd_word  (rd_word),
    .empty    (empty),
    .full     (full),
    .level    (level),
    .drops    (drops),
    .enable   (enable),
    .pop      (pop),
    .clear    (clear)
  );

endmodule

`default_nettype wire

// File: include/adc_rx_tb_util.svh
`ifndef ADC_RX_TB_UTIL_SVH
`define ADC_RX_TB_UTIL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// seven bits for one lane half, msb first
function automatic logic [6:0] lfsr_lane(inout logic [31:0] s);
  logic [6:0] v;
  for (int i = 6; i >= 0; i--) begin
    v[i] = s[31];
    s = lfsr_next(s);
  end
  return v;
endfunction

// reference interleave, fall on odd bits, rise on even, 1:0 zero
function automatic logic [15:0] model_sample(input adc_rx_pkg::lane_pair_t p);
  logic [15:0] s;
  s = '0;
  for (int k = 0; k < 7; k++) begin
    s[2*k+3] = p.fall[k];
    s[2*k+2] = p.rise[k];
  end
  return s;
endfunction

// one apb transfer, inputs driven 2 units after the edge
// lat counts cycles from setup to the pready cycle
task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err, output int lat);
  int n;
  @(posedge adc0_clk);
  #2;
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = wr;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  @(posedge adc0_clk);
  #2;
  apb_req.penable = 1'b1;
  n = 1;
  while (!apb_rsp.pready && n < 16) begin
    @(posedge adc0_clk);
    #2;
    n++;
  end
  rdata = apb_rsp.prdata;
  err   = apb_rsp.pslverr;
  lat   = n;
  @(posedge adc0_clk);
  #2;
  apb_req.psel    = 1'b0;
  apb_req.penable = 1'b0;
endtask

`endif

// File: verification/adc_rx_tb.sv
`default_nettype none

module adc_rx_tb;

  import adc_rx_pkg::*;

  localparam int DEPTH      = 16;
  localparam int RST_CYCLES = 16;
  // roughly ten times the longest expected run
  localparam int WATCHDOG_CYCLES = 4000;

  logic         adc0_clk   = 1'b0;
  logic         cfg_rst    = 1'b1;
  adc_pins_t    adc_in     = '0;
  apb_req_t     apb_req    = '0;
  apb_rsp_t     apb_rsp;
  // lane source, one lfsr step per bit
  logic [31:0]  lfsr_state = 32'h7c4d_b0a0;
  logic         lanes_on   = 1'b0;
  // ovr pulse requests, main side and driver side
  int           ovr_req    = 0;
  int           ovr_done   = 0;
  // modeled words, one per driven cycle
  sample_word_t model_q[$];
  int           run_start  = 0;
  int           run_base   = 0;
  // last response
  logic [31:0]  rdata;
  logic         rerr;
  int           nwords;
  logic [7:0]   wide_addr;

  `include "adc_rx_tb_util.svh"

  adc_rx_top #(
    .FIFO_DEPTH (DEPTH)
  ) i_dut (
    .adc0_clk (adc0_clk),
    .cfg_rst  (cfg_rst),
    .adc_in   (adc_in),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
  );

  always #20 adc0_clk = ~adc0_clk;

  ////////////////////
  // checks
  ////////////////////

  task automatic halt_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
      halt_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("t=%0t %s", $time, what);
      halt_run();
    end
  endtask

  // both halves of a word from the interleave rule
  function automatic sample_word_t model_word(input adc_pins_t p);
    sample_word_t w;
    w.a = model_sample(p.a);
    w.b = model_sample(p.b);
    return w;
  endfunction

  ////////////////////
  // bus helpers
  ////////////////////

  // setup, access, respond, so pready two cycles after setup
  task automatic bus_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
    int lat;
    apb_xfer(wr, addr, wdata, rdata, rerr, lat);
    check_eq("pready latency", 32'd2, lat);
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata, input logic exp_err);
    bus_xfer(1'b1, addr, wdata);
    check_eq("pslverr", {31'd0, exp_err}, {31'd0, rerr});
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp,
                            input logic exp_err, input string name);
    bus_xfer(1'b0, addr, 32'd0);
    check_eq("pslverr", {31'd0, exp_err}, {31'd0, rerr});
    check_eq(name, exp, rdata);
  endtask

  // unmapped address, only the error flag matters
  task automatic err_read(input logic [3:0] addr);
    bus_xfer(1'b0, addr, 32'd0);
    check_eq("pslverr", 32'd1, {31'd0, rerr});
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc0_clk);
  endtask

  ////////////////////
  // stimulus control
  ////////////////////

  // flags change on the falling edge, away from the driver
  task automatic set_lanes(input logic on);
    @(negedge adc0_clk);
    lanes_on = on;
    if (on) begin
      run_start = model_q.size();
    end
  endtask

  task automatic pulse_ovr();
    @(negedge adc0_clk);
    ovr_req++;
  endtask

  // first word picks the alignment, the rest must follow in order
  task automatic match_run(input sample_word_t got, input int idx);
    int pos;
    pos = -1;
    if (idx == 0) begin
      for (int i = run_start; i < model_q.size(); i++) begin
        if (pos < 0 && model_q[i] === got) begin
          pos = i;
        end
      end
      check_true(pos >= 0, "first word read matches no modeled word");
      run_base = pos;
    end
    check_true(run_base + idx < model_q.size(), "more words read than were modeled");
    check_eq("prdata", model_q[run_base+idx], got);
  endtask

  // read DATA until STATUS says empty
  task automatic drain_buffer(output int n);
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n <= DEPTH) begin
      bus_xfer(1'b0, REG_STATUS, 32'd0);
      if (rdata[0]) begin
        done = 1'b1;
      end else begin
        bus_xfer(1'b0, REG_DATA, 32'd0);
        check_eq("pslverr", 32'd0, {31'd0, rerr});
        match_run(rdata, n);
        n++;
      end
    end
    check_true(done, "buffer did not drain");
  endtask

  ////////////////////
  // lane driver
  ////////////////////

  always @(posedge adc0_clk) begin
    #2;
    if (lanes_on) begin
      adc_in.a.rise = lfsr_lane(lfsr_state);
      adc_in.a.fall = lfsr_lane(lfsr_state);
      adc_in.b.rise = lfsr_lane(lfsr_state);
      adc_in.b.fall = lfsr_lane(lfsr_state);
      model_q.push_back(model_word(adc_in));
    end else begin
      // idle lanes
      adc_in.a = '0;
      adc_in.b = '0;
    end
    // one cycle high per request
    adc_in.ovr = (ovr_req != ovr_done);
    ovr_done   = ovr_req;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge adc0_clk);
    $display("t=%0t watchdog expired before the tests finished", $time);
    halt_run();
  end

  ////////////////////
  // tests
  ////////////////////

  initial begin
    repeat (RST_CYCLES) @(posedge adc0_clk);
    #2;
    cfg_rst = 1'b0;
    // after reset, idle bus and empty buffer
    check_eq("pready", 32'd0, {31'd0, apb_rsp.pready});
    read_check(REG_STATUS, 32'h0000_0001, 1'b0, "status");
    read_check(REG_CTRL, 32'd0, 1'b0, "ctrl");
    read_check(REG_DROPS, 32'd0, 1'b0, "drops");

    // short capture, fewer words than the depth
    set_lanes(1'b1);
    wait_cycles(4);
    reg_write(REG_CTRL, 32'd1, 1'b0);
    wait_cycles(10);
    reg_write(REG_CTRL, 32'd0, 1'b0);
    // pipeline empties out
    wait_cycles(6);
    set_lanes(1'b0);
    drain_buffer(nwords);
    check_true(nwords > 0 && nwords < DEPTH, "short capture word count out of range");
    read_check(REG_DROPS, 32'd0, 1'b0, "drops");

    // long capture, buffer overflows
    set_lanes(1'b1);
    wait_cycles(4);
    reg_write(REG_CTRL, 32'd1, 1'b0);
    wait_cycles(40);
    reg_write(REG_CTRL, 32'd0, 1'b0);
    wait_cycles(6);
    set_lanes(1'b0);
    // full, level at depth
    read_check(REG_STATUS, {16'd0, 8'(DEPTH), 8'h02}, 1'b0, "status");
    bus_xfer(1'b0, REG_DROPS, 32'd0);
    check_true(rdata != 32'd0, "drop count is zero after overflow");
    drain_buffer(nwords);
    check_eq("word count", DEPTH, nwords);
    reg_write(REG_DROPS, 32'd0, 1'b0);
    read_check(REG_DROPS, 32'd0, 1'b0, "drops");

    // out of range, sticky until write one
    pulse_ovr();
    wait_cycles(4);
    read_check(REG_STATUS, 32'h0000_0005, 1'b0, "status");
    wait_cycles(8);
    read_check(REG_STATUS, 32'h0000_0005, 1'b0, "status");
    reg_write(REG_STATUS, 32'h0000_0004, 1'b0);
    read_check(REG_STATUS, 32'h0000_0001, 1'b0, "status");

    // bus errors
    read_check(REG_DATA, 32'd0, 1'b1, "prdata");
    // paddr is 4 bits, 0x10 wraps onto CTRL
    wide_addr = 8'h10;
    read_check(wide_addr[3:0], 32'd0, 1'b0, "ctrl alias");
    err_read(4'h2);
    err_read(4'h6);
    reg_write(4'h2, 32'd1, 1'b1);
    reg_write(4'h6, 32'd1, 1'b1);
    read_check(REG_CTRL, 32'd0, 1'b0, "ctrl");

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/adc_rx_pkg.sv
design/sample_assembler.sv
design/sample_fifo.sv
design/drop_counter.sv
design/apb_reg_fsm.sv
design/adc_rx_top.sv
verification/adc_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the adc_rx testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module adc_rx_tb \
  -f src.f \
  -o adc_rx_sim

# exit status of the simulation is the result
./obj_dir/adc_rx_sim
